// ==== fetch_axi.f ====
hw/fetch_pkg.sv
hw/line_ctl_if.sv
hw/fetch_ctrl.sv
hw/ar_issue.sv
hw/line_buffer.sv
hw/fetch_axi.sv
bench/axi_rd_slave.sv
bench/tb_fetch_axi.sv

// ==== Bender.yml ====
package:
  name: fetch_axi

sources:
  # design, package first
  - files:
      - hw/fetch_pkg.sv
      - hw/line_ctl_if.sv
      - hw/fetch_ctrl.sv
      - hw/ar_issue.sv
      - hw/line_buffer.sv
      - hw/fetch_axi.sv
  # bench, simulation only
  - target: any(simulation, test)
    files:
      - bench/axi_rd_slave.sv
      - bench/tb_fetch_axi.sv

// ==== bench/tb_fetch_axi.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_axi;

    localparam int SEED         = 63363;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_REQ      = 46;           // fetches issued by the stimulus

    logic             clock;
    logic             reset;
    logic             rw_valid_i;
    fetch_pkg::addr_t rw_addr_i;
    logic             rw_ready_o;
    fetch_pkg::data_t data_read_o;
    logic             fetch_err_o;
    logic             instr_fetching_o;
    logic             axi_ar_valid_o;
    logic             axi_ar_ready_i;
    fetch_pkg::addr_t axi_ar_addr_o;
    logic             axi_r_valid_i;
    logic             axi_r_ready_o;
    fetch_pkg::data_t axi_r_data_i;
    fetch_pkg::resp_t axi_r_resp_i;
    logic             axi_r_last_i;

    // expected answers in request order
    fetch_pkg::data_t exp_word_q [$];
    logic             exp_err_q [$];
    logic             exp_burst_q [$];
    fetch_pkg::addr_t exp_line_q [$];

    int          seed;
    logic        held_ok  = 1'b0;               // model of the held line
    logic [26:0] held_tag = '0;
    logic        was_idle = 1'b1;               // request presented with FSM idle
    int          data_errs  = 0;
    int          addr_errs  = 0;
    int          flag_errs  = 0;
    int          other_errs = 0;

    int               ar_cnt   = 0;             // handshakes since the last answer
    fetch_pkg::addr_t ar_last  = '0;
    logic             ar_hold  = 1'b0;          // ar pending at the last edge
    fetch_pkg::addr_t ar_hold_addr = '0;
    logic             busy_q   = 1'b0;          // request accepted and not yet answered
    logic             miss_q   = 1'b0;          // miss outstanding
    logic             ar_pend  = 1'b0;          // ar handshake still owed
    logic             ready_q  = 1'b0;
    logic             exp_fetch;

    fetch_axi i_dut (.*);

    axi_rd_slave #(.SEED(SEED)) i_slave (
        .clock      (clock),
        .reset      (reset),
        .ar_valid_i (axi_ar_valid_o),
        .ar_ready_o (axi_ar_ready_i),
        .ar_addr_i  (axi_ar_addr_o),
        .r_valid_o  (axi_r_valid_i),
        .r_ready_i  (axi_r_ready_o),
        .r_data_o   (axi_r_data_i),
        .r_resp_o   (axi_r_resp_i),
        .r_last_o   (axi_r_last_i)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // expected word, error and burst for one fetch with 32-byte lines
    function automatic void ref_fetch(input fetch_pkg::addr_t addr, input logic line_ok,
                                      input logic [26:0] line_tag,
                                      output fetch_pkg::data_t word, output logic err,
                                      output logic burst);
        fetch_pkg::addr_t a;
        a     = {addr[31:3], 3'b000};           // 8-byte aligned beat address
        burst = !(line_ok && line_tag == addr[31:5]);
        err   = (addr[15:12] == 4'hf);
        word  = err ? '0 : {~a, a};
    endfunction

    task automatic check_data(input string name, input fetch_pkg::data_t got,
                              input fetch_pkg::data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_addr(input string name, input fetch_pkg::addr_t got,
                              input fetch_pkg::addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            addr_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
            flag_errs++;
        end
    endtask

    task automatic check_quiet();
        check_flag("axi_ar_valid_o", axi_ar_valid_o, 1'b0);
        check_flag("axi_r_ready_o", axi_r_ready_o, 1'b0);
        check_flag("rw_ready_o", rw_ready_o, 1'b0);
        check_flag("instr_fetching_o", instr_fetching_o, 1'b0);
    endtask

    // drives one request
    // keep holds rw_valid_i into the next one
    task automatic fetch(input fetch_pkg::addr_t addr, input logic keep);
        fetch_pkg::data_t word;
        logic             err;
        logic             burst;
        int               waits;
        ref_fetch(addr, held_ok, held_tag, word, err, burst);
        exp_word_q.push_back(word);
        exp_err_q.push_back(err);
        exp_burst_q.push_back(burst);
        exp_line_q.push_back({addr[31:5], 5'b0});
        if (burst) begin
            held_ok  = !err;                    // bad line never kept
            held_tag = addr[31:5];
        end
        rw_valid_i = 1'b1;
        rw_addr_i  = addr;
        waits      = 0;
        do begin
            @(negedge clock);
            waits++;
        end while (!rw_ready_o);
        if (!burst && was_idle && waits != 1) begin
            $display("hit on %h answered after %0d cycles instead of 1", addr, waits);
            other_errs++;
        end
        if (keep) begin
            was_idle = 1'b0;                    // next address goes out right away
        end else begin
            rw_valid_i = 1'b0;
            @(negedge clock);
            was_idle = 1'b1;
        end
    endtask

    task automatic compare_answer();
        if (exp_word_q.size() == 0) begin
            $display("rw_ready_o pulsed at %0t with no request outstanding", $time);
            other_errs++;
        end else begin
            check_data("data_read_o", data_read_o, exp_word_q.pop_front());
            check_flag("fetch_err_o", fetch_err_o, exp_err_q.pop_front());
            check_flag("ar_handshake", ar_cnt != 0, exp_burst_q[0]);
            if (ar_cnt > 1) begin
                $display("%0d address handshakes for one fetch at %0t", ar_cnt, $time);
                other_errs++;
            end
            if (exp_burst_q.pop_front() && ar_cnt != 0) begin
                check_addr("axi_ar_addr_o", ar_last, exp_line_q[0]);
            end
            void'(exp_line_q.pop_front());
        end
    endtask

    // bus and answer monitor on pre-edge values at each rising edge
    always @(posedge clock) begin
        if (reset) begin
            if (ar_hold) begin
                check_addr("axi_ar_addr_o", axi_ar_addr_o, ar_hold_addr);
            end
            ar_hold      = axi_ar_valid_o && !axi_ar_ready_i;
            ar_hold_addr = axi_ar_addr_o;
            check_flag("axi_ar_valid_o", axi_ar_valid_o, ar_pend);
            if (axi_ar_valid_o && axi_ar_ready_i) begin
                ar_cnt  = ar_cnt + 1;
                ar_last = axi_ar_addr_o;
            end
            exp_fetch = miss_q && !rw_ready_o;
            check_flag("instr_fetching_o", instr_fetching_o, exp_fetch);
            check_flag("axi_r_ready_o", axi_r_ready_o, exp_fetch && !ar_pend);
            if (ar_pend && axi_ar_ready_i) begin
                ar_pend = 1'b0;                 // address taken on this edge
            end
            if (rw_ready_o && ready_q) begin
                $display("rw_ready_o high for more than one cycle at %0t", $time);
                other_errs++;
            end
            ready_q = rw_ready_o;
            if (rw_valid_i && !busy_q) begin
                busy_q  = 1'b1;                 // accepted on this edge
                miss_q  = (exp_burst_q.size() != 0) && exp_burst_q[0];
                ar_pend = miss_q;
            end
            if (rw_ready_o) begin
                compare_answer();
                busy_q = 1'b0;
                miss_q = 1'b0;
                ar_cnt = 0;
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        seed       = SEED;
        reset      = 1'b0;
        rw_valid_i = 1'b0;
        rw_addr_i  = '0;
        repeat (RESET_CYCLES) @(negedge clock);
        check_quiet();
        reset = 1'b1;
        @(negedge clock);
        check_quiet();
        fetch(32'h0000_1000, 1'b0);             // cold miss
        fetch(32'h0000_1008, 1'b0);             // same line so hits
        fetch(32'h0000_1013, 1'b0);
        fetch(32'h0000_1018, 1'b0);
        fetch(32'h0000_1004, 1'b0);
        fetch(32'h0000_2040, 1'b0);             // other line
        fetch(32'h0000_100c, 1'b0);             // old line refetched
        repeat (24) begin
            rnd = $random(seed);
            fetch(32'h0000_3000 + rnd[6:0], 1'b0);  // mixed hits over four lines
        end
        fetch(32'h0000_f010, 1'b0);             // error region
        fetch(32'h0000_f008, 1'b0);
        fetch(32'h0000_f018, 1'b0);
        repeat (12) begin
            rnd = $random(seed);
            fetch(32'h0001_0000 + rnd[6:0], 1'b1);  // back to back
        end
        rw_valid_i = 1'b0;
        repeat (4) @(negedge clock);
        $display("errors: data %0d, addr %0d, flag %0d, other %0d",
                 data_errs, addr_errs, flag_errs, other_errs);
        if (data_errs + addr_errs + flag_errs + other_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog allows 40 cycles for each fetch
    initial begin
        repeat (NUM_REQ * 40 + RESET_CYCLES) @(posedge clock);
        $display("watchdog expired, the fetch unit stopped answering");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/axi_rd_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

// read-only axi slave, one burst at a time, memory contents computed from the address
module axi_rd_slave #(
    parameter int SEED = 1
) (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic             ar_valid_i,
    output logic                  ar_ready_o,
    input  wire fetch_pkg::addr_t ar_addr_i,
    output logic                  r_valid_o,
    input  wire logic             r_ready_i,
    output fetch_pkg::data_t      r_data_o,
    output fetch_pkg::resp_t      r_resp_o,
    output logic                  r_last_o
);

    localparam fetch_pkg::resp_t RESP_SLVERR = 2'b10;

    int               seed;
    fetch_pkg::addr_t line_addr;    // taken at the ar handshake
    fetch_pkg::addr_t beat_addr;

    // 0 to 3 wait cycles
    function automatic int stall_cycles();
        return $random(seed) & 3;
    endfunction

    // outputs change on the falling edge only
    initial begin
        seed       = SEED;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_data_o   = '0;
        r_resp_o   = fetch_pkg::RESP_OKAY;
        r_last_o   = 1'b0;
        forever begin
            @(negedge clock);
            if (reset && ar_valid_i) begin
                repeat (stall_cycles()) @(negedge clock);
                ar_ready_o = 1'b1;
                line_addr  = ar_addr_i;     // valid held, address stable
                @(negedge clock);           // handshake on the edge in between
                ar_ready_o = 1'b0;
                for (int b = 0; b < fetch_pkg::LINE_BEATS; b++) begin
                    r_valid_o = 1'b0;
                    r_last_o  = 1'b0;
                    repeat (stall_cycles()) @(negedge clock);
                    beat_addr = line_addr + b * 8;
                    r_valid_o = 1'b1;
                    r_data_o  = {~beat_addr, beat_addr};
                    r_last_o  = (b == fetch_pkg::LINE_BEATS - 1);
                    // error region: address bits 15 to 12 all ones, bad beat 2
                    if (b == 2 && line_addr[15:12] == 4'hf) begin
                        r_resp_o = RESP_SLVERR;
                    end else begin
                        r_resp_o = fetch_pkg::RESP_OKAY;
                    end
                    while (!r_ready_i) @(negedge clock);
                    @(negedge clock);       // beat taken on the edge in between
                end
                r_valid_o = 1'b0;
                r_last_o  = 1'b0;
                r_resp_o  = fetch_pkg::RESP_OKAY;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/fetch_axi.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_axi (
    input  wire logic             clock,
    input  wire logic             reset,

    // fetch stage
    input  wire logic             rw_valid_i,
    input  wire fetch_pkg::addr_t rw_addr_i,
    output logic                  rw_ready_o,
    output fetch_pkg::data_t      data_read_o,
    output logic                  fetch_err_o,
    output logic                  instr_fetching_o,

    // axi read address channel
    output logic                  axi_ar_valid_o,
    input  wire logic             axi_ar_ready_i,
    output fetch_pkg::addr_t      axi_ar_addr_o,

    // axi read data channel
    input  wire logic             axi_r_valid_i,
    output logic                  axi_r_ready_o,
    input  wire fetch_pkg::data_t axi_r_data_i,
    input  wire fetch_pkg::resp_t axi_r_resp_i,
    input  wire logic             axi_r_last_i
);

    fetch_pkg::fetch_addr_u req_addr;   // request split into tag, beat, offset
    logic                   ar_issue;
    logic                   ar_done;

    assign req_addr = fetch_pkg::fetch_addr_u'(rw_addr_i);

    line_ctl_if line_if ();

    // sequencing
    fetch_ctrl i_ctrl (
        .clock      (clock),
        .reset      (reset),
        .rw_valid_i (rw_valid_i),
        .ar_issue_o (ar_issue),
        .ar_done_i  (ar_done),
        .r_valid_i  (axi_r_valid_i),
        .r_last_i   (axi_r_last_i),
        .r_ready_o  (axi_r_ready_o),
        .rw_ready_o (rw_ready_o),
        .fetching_o (instr_fetching_o),
        .line       (line_if.ctrl)
    );

    // ar channel
    ar_issue i_ar (
        .clock      (clock),
        .reset      (reset),
        .req_addr_i (req_addr),
        .issue_i    (ar_issue),
        .ar_ready_i (axi_ar_ready_i),
        .ar_valid_o (axi_ar_valid_o),
        .ar_addr_o  (axi_ar_addr_o),
        .done_o     (ar_done)
    );

    // single line store plus answer register
    line_buffer i_line (
        .clock      (clock),
        .reset      (reset),
        .req_addr_i (req_addr),
        .r_data_i   (axi_r_data_i),
        .r_resp_i   (axi_r_resp_i),
        .line       (line_if.lbuf),
        .word_o     (data_read_o),
        .err_o      (fetch_err_o)
    );

endmodule

`default_nettype wire

// ==== hw/line_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module line_buffer (
    input  wire logic                   clock,
    input  wire logic                   reset,

    input  wire fetch_pkg::fetch_addr_u req_addr_i,  // current request
    input  wire fetch_pkg::data_t       r_data_i,    // r channel beat
    input  wire fetch_pkg::resp_t       r_resp_i,

    line_ctl_if.lbuf                    line,

    output fetch_pkg::data_t            word_o,      // answer word
    output logic                        err_o        // answer carries bus error
);

    fetch_pkg::data_t               beat_q [fetch_pkg::LINE_BEATS];
    logic [fetch_pkg::TAG_W-1:0]    tag_q;
    logic                           valid_q;
    logic [fetch_pkg::BEAT_W-1:0]   cnt_q;      // next beat slot to write
    logic                           err_q;      // sticky over one fill

    logic                           beat_bad;   // taken beat has a bad response
    logic                           err_now;    // error including this cycle's beat
    logic                           fwd;        // requested beat is arriving right now
    fetch_pkg::data_t               sel_word;

    assign beat_bad = line.beat_take && (r_resp_i != fetch_pkg::RESP_OKAY);
    assign err_now  = err_q || beat_bad;

    // lookup against the held line
    assign line.hit      = valid_q && (tag_q == req_addr_i.fields.tag);
    assign line.fill_err = err_q;

    // bypass so the last beat can be answered without waiting a cycle
    assign fwd      = line.beat_take && (cnt_q == req_addr_i.fields.beat);
    assign sel_word = fwd ? r_data_i : beat_q[req_addr_i.fields.beat];

    // line status
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            valid_q <= 1'b0;
            cnt_q   <= '0;
            err_q   <= 1'b0;
        end else begin
            if (line.fill_start) begin
                valid_q <= 1'b0;            // line is being replaced
                cnt_q   <= '0;
                err_q   <= 1'b0;
            end else begin
                if (line.beat_take) begin
                    cnt_q <= cnt_q + 1'b1;  // wraps after the fourth beat
                end
                if (beat_bad) begin
                    err_q <= 1'b1;
                end
                if (line.fill_done) begin
                    valid_q <= !err_now;    // a bad line is never reused
                end
            end
        end
    end

    // tag taken when the fill starts
    always_ff @(posedge clock) begin
        if (line.fill_start) begin
            tag_q <= req_addr_i.fields.tag;
        end
    end

    // beat storage
    always_ff @(posedge clock) begin
        if (line.beat_take) begin
            beat_q[cnt_q] <= r_data_i;
        end
    end

    // answer register, zero data on error
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            err_o <= 1'b0;
        end else if (line.word_load) begin
            err_o <= err_now;
        end
    end

    always_ff @(posedge clock) begin
        if (line.word_load) begin
            word_o <= err_now ? '0 : sel_word;
        end
    end

endmodule

`default_nettype wire

// ==== hw/ar_issue.sv ====
`timescale 1ns/1ns
`default_nettype none

module ar_issue (
    input  wire logic                  clock,
    input  wire logic                  reset,

    input  wire fetch_pkg::fetch_addr_u req_addr_i, // request address, held by requester
    input  wire logic                  issue_i,     // start a line read

    input  wire logic                  ar_ready_i,
    output logic                       ar_valid_o,
    output fetch_pkg::addr_t           ar_addr_o,

    output logic                       done_o       // handshake this cycle
);

    fetch_pkg::fetch_addr_u line_addr;   // request rounded down to its line
    logic                   valid_q;

    // keep the tag, zero beat and byte offset
    always_comb begin
        line_addr             = req_addr_i;
        line_addr.fields.beat = '0;
        line_addr.fields.off  = '0;
    end

    // valid set on issue, dropped once the slave takes it
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            valid_q <= 1'b0;
        end else if (issue_i) begin
            valid_q <= 1'b1;
        end else if (valid_q && ar_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    // address only moves on issue, so stable for the whole valid phase
    always_ff @(posedge clock) begin
        if (issue_i) begin
            ar_addr_o <= line_addr.raw;
        end
    end

    assign ar_valid_o = valid_q;
    assign done_o     = valid_q && ar_ready_i;

endmodule

`default_nettype wire

// ==== hw/fetch_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_ctrl (
    input  wire logic clock,
    input  wire logic reset,

    input  wire logic rw_valid_i,   // fetch request pending

    output logic      ar_issue_o,   // load ar holder
    input  wire logic ar_done_i,    // ar handshake seen

    input  wire logic r_valid_i,
    input  wire logic r_last_i,
    output logic      r_ready_o,

    output logic      rw_ready_o,   // one cycle answer strobe
    output logic      fetching_o,   // miss outstanding

    line_ctl_if.ctrl  line
);

    // state codes
    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_ADDR   = 3'd1;   // waiting for ar handshake
    localparam logic [2:0] ST_FILL   = 3'd2;   // taking r beats
    localparam logic [2:0] ST_REPLY  = 3'd3;   // answer after a fill
    localparam logic [2:0] ST_ANSWER = 3'd4;   // answer after a hit

    logic [2:0] state_q;
    logic [2:0] state_d;

    logic req_hit;      // request served from the held line
    logic req_miss;     // request needs a burst
    logic beat_in;      // r beat accepted this cycle
    logic last_in;      // final beat of the burst accepted

    assign req_hit  = (state_q == ST_IDLE) && rw_valid_i && line.hit;
    assign req_miss = (state_q == ST_IDLE) && rw_valid_i && !line.hit;

    // r_ready is held high for the whole fill, so valid alone means a beat
    assign beat_in  = (state_q == ST_FILL) && r_valid_i;
    assign last_in  = beat_in && r_last_i;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;                  // stay by default
        case (state_q)
            ST_IDLE: begin
                if (req_hit) begin
                    state_d = ST_ANSWER;
                end else if (req_miss) begin
                    state_d = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (ar_done_i) begin
                    state_d = ST_FILL;      // r_ready rises next cycle
                end
            end
            ST_FILL: begin
                if (last_in) begin
                    state_d = ST_REPLY;
                end
            end
            ST_REPLY: begin
                state_d = ST_IDLE;          // one cycle strobe only
            end
            ST_ANSWER: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // a miss clears the line and arms the ar holder together
    assign line.fill_start = req_miss;
    assign ar_issue_o      = req_miss;

    // once a beat came back bad the line is dropped anyway,
    // rest of the burst is only drained
    assign line.beat_take  = beat_in && !line.fill_err;
    assign line.fill_done  = last_in;

    // word is latched one cycle ahead of the strobe,
    // on the last beat the storage forwards the incoming data
    assign line.word_load  = req_hit || last_in;

    assign r_ready_o  = (state_q == ST_FILL);
    assign rw_ready_o = (state_q == ST_REPLY) || (state_q == ST_ANSWER);
    assign fetching_o = (state_q == ST_ADDR) || (state_q == ST_FILL);

endmodule

`default_nettype wire

// ==== hw/line_ctl_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// control and status between the fetch FSM and the line storage
interface line_ctl_if;

    logic hit;          // line valid and tag equal, combinational
    logic fill_start;   // new burst, take tag, clear counter and error
    logic beat_take;    // write current r beat and step the counter
    logic fill_done;    // burst over, line valid unless error seen
    logic fill_err;     // sticky error of the running fill
    logic word_load;    // latch selected word into output register

    // FSM side
    modport ctrl (
        input  hit,
        input  fill_err,
        output fill_start,
        output beat_take,
        output fill_done,
        output word_load
    );

    // storage side
    modport lbuf (
        output hit,
        output fill_err,
        input  fill_start,
        input  beat_take,
        input  fill_done,
        input  word_load
    );

endinterface

`default_nettype wire

// ==== hw/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // bus and word geometry
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 64;             // one fetch word = one bus beat

    // line geometry, 4 beats of 8 bytes
    localparam int LINE_BEATS = 4;
    localparam int BEAT_W     = 2;              // beat index inside a line
    localparam int OFF_W      = 3;              // byte offset inside a beat
    localparam int TAG_W      = ADDR_W - BEAT_W - OFF_W;   // 27 bits

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [1:0]        resp_t;          // axi rresp

    // only okay counts as good data, exokay never comes back on a plain read
    localparam resp_t RESP_OKAY = 2'b00;

    // one fetch address, seen either as the bus word or split for line lookup
    typedef union packed {
        addr_t raw;                             // goes out on ar, bench compares this
        struct packed {
            logic [TAG_W-1:0]  tag;             // line match
            logic [BEAT_W-1:0] beat;            // word select within the line
            logic [OFF_W-1:0]  off;             // byte in word, ignored by fetch
        } fields;
    } fetch_addr_u;

endpackage

`default_nettype wire
